// ==== src.f ====
ladybird_config.sv
ladybird_bus.sv
ladybird_inst_ram.sv
ladybird_data_ram.sv
ladybird_bus_decoder.sv
ladybird_mem_subsys.sv
tb_clock_gen.sv
tb_ladybird_mem_subsys.sv

// ==== tb_ladybird_mem_subsys.sv ====
`default_nettype none

module tb_ladybird_mem_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned XLEN         = ladybird_config::XLEN;
  localparam int unsigned STRB_W       = ladybird_config::STRB_W;
  localparam int unsigned ADDR_W       = 4;
  localparam int unsigned DEPTH        = 2 ** ADDR_W;
  localparam int unsigned HI_W         = XLEN - ADDR_W - 3; // address bits that wrap.
  localparam int unsigned CLK_PERIOD   = 8;
  localparam int unsigned RESET_CYCLES = 10;

  // cycles spent by each test, as the tasks below issue them.
  localparam int unsigned BOOT_CYCLES  = DEPTH + 1;
  localparam int unsigned WORD_WRITES  = 6;
  localparam int unsigned WORD_CYCLES  = WORD_WRITES + DEPTH;
  localparam int unsigned STRB_ROUNDS  = 8;
  localparam int unsigned STRB_CYCLES  = 3 * STRB_ROUNDS;
  localparam int unsigned INST_CYCLES  = 3 * 5;
  localparam int unsigned ALT_ROUNDS   = 2;
  localparam int unsigned ALT_CYCLES   = 5 * ALT_ROUNDS;
  localparam int unsigned SRST_CYCLES  = 2 + 2 * DEPTH;
  localparam int unsigned TOTAL_CYCLES = RESET_CYCLES + 1 + BOOT_CYCLES + WORD_CYCLES
                                         + STRB_CYCLES + INST_CYCLES + ALT_CYCLES
                                         + SRST_CYCLES;

  logic              clk;
  logic              anrst;
  logic              nrst;
  logic              bus_req;
  logic [XLEN-1:0]   bus_addr;
  logic [STRB_W-1:0] bus_wstrb;
  logic [XLEN-1:0]   bus_wdata;
  logic              bus_gnt;
  logic [XLEN-1:0]   bus_rdata;
  logic              bus_data_gnt;

  logic [XLEN-1:0] inst_model [DEPTH];
  logic [XLEN-1:0] data_model [DEPTH];
  int              errors;
  int              checks;
  int              tests_run;
  int              tests_bad;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock_gen (
    .clk   (clk),
    .anrst (anrst)
  );

  ladybird_mem_subsys #(
    .INST_ADDR_W (ADDR_W),
    .DATA_ADDR_W (ADDR_W)
  ) DUT (
    .clk          (clk),
    .anrst        (anrst),
    .nrst         (nrst),
    .bus_req      (bus_req),
    .bus_addr     (bus_addr),
    .bus_wstrb    (bus_wstrb),
    .bus_wdata    (bus_wdata),
    .bus_gnt      (bus_gnt),
    .bus_rdata    (bus_rdata),
    .bus_data_gnt (bus_data_gnt)
  );

  function automatic logic [XLEN-1:0] make_addr(input ladybird_config::region_e region,
                                                input int unsigned idx,
                                                input logic [HI_W-1:0] hi);
    return {region, hi, idx[ADDR_W-1:0], 2'b00};
  endfunction

  function automatic logic [HI_W-1:0] rand_hi();
    logic [31:0] r;
    r = $urandom();
    return r[HI_W-1:0];
  endfunction

  // byte lanes with a set strobe take the new data.
  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old_word,
                                                  input logic [XLEN-1:0] new_word,
                                                  input logic [STRB_W-1:0] strb);
    logic [XLEN-1:0] res;
    res = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors != err0) begin
      tests_bad++;
      $display("test %-24s %0d mismatches", name, errors - err0);
    end else begin
      $display("test %-24s ok", name);
    end
  endtask

  task automatic reset_models();
    for (int i = 0; i < DEPTH; i++) begin
      // the image past the real code is filled with nop.
      inst_model[i] = (i >= 14) ? ladybird_config::NOP() : ladybird_config::boot_word(i);
      data_model[i] = '0;
    end
  endtask

  task automatic drive_idle();
    bus_req   = 1'b0;
    bus_addr  = '0;
    bus_wstrb = '0;
    bus_wdata = '0;
  endtask

  task automatic write_word(input logic [XLEN-1:0] addr, input logic [STRB_W-1:0] strb,
                            input logic [XLEN-1:0] data);
    bus_req   = 1'b1;
    bus_addr  = addr;
    bus_wstrb = strb;
    bus_wdata = data;
    @(negedge clk);
    check_valid("bus_gnt", bus_gnt, 1'b1);
    drive_idle();
  endtask

  // the response is due exactly one cycle after the request.
  task automatic read_expect(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] exp);
    bus_req   = 1'b1;
    bus_addr  = addr;
    bus_wstrb = '0;
    bus_wdata = '0;
    @(negedge clk);
    check_valid("bus_gnt", bus_gnt, 1'b1);
    check_valid("bus_data_gnt", bus_data_gnt, 1'b1);
    check_word($sformatf("bus_rdata @%h", addr), bus_rdata, exp);
    drive_idle();
  endtask

  task automatic boot_readback();
    int err0;
    err0 = errors;
    for (int i = 0; i < DEPTH; i++) begin
      read_expect(make_addr(ladybird_config::REGION_INST, i, '0), inst_model[i]);
    end
    @(negedge clk);
    check_valid("bus_data_gnt", bus_data_gnt, 1'b0); // an idle cycle leaves no pulse.
    report_test("boot_readback", err0);
  endtask

  task automatic data_word_rw();
    int              err0;
    int unsigned     idx;
    logic [XLEN-1:0] data;
    err0 = errors;
    for (int n = 0; n < WORD_WRITES; n++) begin
      idx  = $urandom_range(DEPTH - 1);
      data = $urandom();
      write_word(make_addr(ladybird_config::REGION_DATA, idx, rand_hi()), '1, data);
      data_model[idx] = data;
    end
    for (int i = 0; i < DEPTH; i++) begin
      read_expect(make_addr(ladybird_config::REGION_DATA, i, rand_hi()), data_model[i]);
    end
    report_test("data_word_rw", err0);
  endtask

  task automatic byte_strobes();
    int                err0;
    int unsigned       idx;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   data;
    logic [STRB_W-1:0] strb;
    err0 = errors;
    for (int n = 0; n < STRB_ROUNDS; n++) begin
      idx  = $urandom_range(DEPTH - 1);
      addr = make_addr(ladybird_config::REGION_DATA, idx, rand_hi());
      data = $urandom();
      write_word(addr, '1, data);
      data_model[idx] = data;
      data = $urandom();
      strb = STRB_W'($urandom_range(2 ** STRB_W - 1, 1));
      write_word(addr, strb, data);
      data_model[idx] = merge_bytes(data_model[idx], data, strb);
      read_expect(addr, data_model[idx]);
    end
    report_test("byte_strobes", err0);
  endtask

  task automatic inst_write_independence();
    int              err0;
    int unsigned     idx_list [3] = '{3, 9, 15};
    int unsigned     idx;
    logic [XLEN-1:0] data;
    err0 = errors;
    foreach (idx_list[k]) begin
      idx  = idx_list[k];
      data = $urandom();
      write_word(make_addr(ladybird_config::REGION_INST, idx, '0), '1, data);
      inst_model[idx] = data;
      read_expect(make_addr(ladybird_config::REGION_INST, idx, '0), inst_model[idx]);
      read_expect(make_addr(ladybird_config::REGION_INST, (idx + DEPTH - 1) % DEPTH, '0),
                  inst_model[(idx + DEPTH - 1) % DEPTH]);
      read_expect(make_addr(ladybird_config::REGION_INST, (idx + 1) % DEPTH, '0),
                  inst_model[(idx + 1) % DEPTH]);
      read_expect(make_addr(ladybird_config::REGION_DATA, idx, '0), data_model[idx]);
    end
    report_test("inst_write_independence", err0);
  endtask

  task automatic alternating_reads();
    int                       err0;
    int unsigned              idx;
    ladybird_config::region_e region;
    logic [XLEN-1:0]          exp_prev;
    logic [XLEN-1:0]          data;
    err0 = errors;
    for (int r = 0; r < ALT_ROUNDS; r++) begin
      for (int k = 0; k < 4; k++) begin
        region = (k % 2 == 0) ? ladybird_config::REGION_INST : ladybird_config::REGION_DATA;
        idx    = $urandom_range(DEPTH - 1);
        if (k > 0) begin
          check_valid("bus_data_gnt", bus_data_gnt, 1'b1);
          check_word("bus_rdata", bus_rdata, exp_prev);
        end
        bus_req   = 1'b1;
        bus_addr  = make_addr(region, idx, '0);
        bus_wstrb = '0;
        exp_prev  = (region == ladybird_config::REGION_INST) ? inst_model[idx] : data_model[idx];
        @(negedge clk);
      end
      check_valid("bus_data_gnt", bus_data_gnt, 1'b1);
      check_word("bus_rdata", bus_rdata, exp_prev);
      // a write follows the last read and must not raise data_gnt.
      region = (r % 2 == 0) ? ladybird_config::REGION_DATA : ladybird_config::REGION_INST;
      idx    = $urandom_range(DEPTH - 1);
      data   = $urandom();
      write_word(make_addr(region, idx, '0), '1, data);
      if (region == ladybird_config::REGION_INST) begin
        inst_model[idx] = data;
      end else begin
        data_model[idx] = data;
      end
      check_valid("bus_data_gnt", bus_data_gnt, 1'b0);
    end
    report_test("alternating_reads", err0);
  endtask

  task automatic sync_reset();
    int err0;
    err0 = errors;
    nrst      = 1'b0;
    bus_req   = 1'b1; // a read during reset is dropped.
    bus_addr  = make_addr(ladybird_config::REGION_DATA, 0, '0);
    bus_wstrb = '0;
    @(negedge clk);
    check_valid("bus_data_gnt", bus_data_gnt, 1'b0);
    nrst = 1'b1;
    drive_idle();
    @(negedge clk);
    check_valid("bus_data_gnt", bus_data_gnt, 1'b0);
    reset_models();
    for (int i = 0; i < DEPTH; i++) begin
      read_expect(make_addr(ladybird_config::REGION_INST, i, '0), inst_model[i]);
    end
    for (int i = 0; i < DEPTH; i++) begin
      read_expect(make_addr(ladybird_config::REGION_DATA, i, '0), data_model[i]);
    end
    report_test("sync_reset", err0);
  endtask

  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD * 2);
    $display("watchdog expired at %0t ns before the tests finished", $time);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(32'hcd2f));
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    tests_bad = 0;
    nrst      = 1'b1;
    drive_idle();
    reset_models();
    wait (anrst === 1'b1);
    @(negedge clk);
    boot_readback();
    data_word_rw();
    byte_strobes();
    inst_write_independence();
    alternating_reads();
    sync_reset();
    $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 10
) (
  output logic clk,
  output logic anrst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // reset is released on a falling edge, half a period away from the DUT's sampling edge.
  initial begin
    anrst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    anrst = 1'b1;
  end

endmodule

`default_nettype wire

// ==== ladybird_mem_subsys.sv ====
`default_nettype none

module ladybird_mem_subsys #(
  parameter int unsigned INST_ADDR_W = 4,
  parameter int unsigned DATA_ADDR_W = 4
) (
  input  logic                               clk,
  input  logic                               anrst,
  input  logic                               nrst,
  input  logic                               bus_req,
  input  logic [ladybird_config::XLEN-1:0]   bus_addr,
  input  logic [ladybird_config::STRB_W-1:0] bus_wstrb,
  input  logic [ladybird_config::XLEN-1:0]   bus_wdata,
  output logic                               bus_gnt,
  output logic [ladybird_config::XLEN-1:0]   bus_rdata,
  output logic                               bus_data_gnt
);

  ladybird_bus inst_bus ();
  ladybird_bus data_bus ();

  ladybird_bus_decoder u_decoder (
    .clk      (clk),
    .anrst    (anrst),
    .nrst     (nrst),
    .req      (bus_req),
    .addr     (bus_addr),
    .wstrb    (bus_wstrb),
    .wdata    (bus_wdata),
    .gnt      (bus_gnt),
    .rdata    (bus_rdata),
    .data_gnt (bus_data_gnt),
    .inst_bus (inst_bus.primary),
    .data_bus (data_bus.primary)
  );

  // boot program lives in the lower half of the address space.
  ladybird_inst_ram #(
    .ADDR_W (INST_ADDR_W)
  ) u_inst_ram (
    .clk   (clk),
    .anrst (anrst),
    .nrst  (nrst),
    .bus   (inst_bus.secondary)
  );

  ladybird_data_ram #(
    .ADDR_W (DATA_ADDR_W)
  ) u_data_ram (
    .clk   (clk),
    .anrst (anrst),
    .nrst  (nrst),
    .bus   (data_bus.secondary)
  );

endmodule

`default_nettype wire

// ==== ladybird_bus_decoder.sv ====
`default_nettype none

module ladybird_bus_decoder (
  input  logic                                clk,
  input  logic                                anrst,
  input  logic                                nrst,
  input  logic                                req,
  input  logic [ladybird_config::XLEN-1:0]    addr,
  input  logic [ladybird_config::STRB_W-1:0]  wstrb,
  input  logic [ladybird_config::XLEN-1:0]    wdata,
  output logic                                gnt,
  output logic [ladybird_config::XLEN-1:0]    rdata,
  output logic                                data_gnt,
  ladybird_bus.primary                        inst_bus,
  ladybird_bus.primary                        data_bus
);

  ladybird_config::region_e req_region;
  ladybird_config::region_e rsp_region; // region that owes the next response.
  logic                     rd_req;

  assign req_region = ladybird_config::region_e'(addr[ladybird_config::XLEN-1]);
  assign rd_req     = req && !(|wstrb);

  // only the addressed RAM sees req, the payload goes to both.
  assign inst_bus.req   = req && (req_region == ladybird_config::REGION_INST);
  assign inst_bus.addr  = addr;
  assign inst_bus.wstrb = wstrb;
  assign inst_bus.wdata = wdata;

  assign data_bus.req   = req && (req_region == ladybird_config::REGION_DATA);
  assign data_bus.addr  = addr;
  assign data_bus.wstrb = wstrb;
  assign data_bus.wdata = wdata;

  assign gnt = (req_region == ladybird_config::REGION_DATA) ? data_bus.gnt : inst_bus.gnt;

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      rsp_region <= ladybird_config::REGION_INST;
    end else if (!nrst) begin
      rsp_region <= ladybird_config::REGION_INST;
    end else if (rd_req) begin
      rsp_region <= req_region;
    end
  end

  // the RAMs answer in the cycle after the request, so the stored region lines up.
  always_comb begin
    if (rsp_region == ladybird_config::REGION_DATA) begin
      rdata    = data_bus.rdata;
      data_gnt = data_bus.data_gnt;
    end else begin
      rdata    = inst_bus.rdata;
      data_gnt = inst_bus.data_gnt;
    end
  end

endmodule

`default_nettype wire

// ==== ladybird_data_ram.sv ====
`default_nettype none

module ladybird_data_ram #(
  parameter int unsigned ADDR_W = 4
) (
  input  logic           clk,
  input  logic           anrst,
  input  logic           nrst,
  ladybird_bus.secondary bus
);

  localparam int unsigned DEPTH = 2 ** ADDR_W;

  logic [ladybird_config::XLEN-1:0] mem [DEPTH];
  logic [ladybird_config::XLEN-1:0] rdata_q;
  logic [ADDR_W-1:0]                idx;
  logic                             wr_req;
  logic                             rd_req;
  logic                             data_gnt_q;

  assign idx    = bus.addr[ADDR_W+1:2];
  assign wr_req = bus.req && (|bus.wstrb);
  assign rd_req = bus.req && !(|bus.wstrb);

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      mem        <= '{default: '0};
      data_gnt_q <= 1'b0;
    end else if (!nrst) begin
      mem        <= '{default: '0}; // requests are dropped while nrst is low.
      data_gnt_q <= 1'b0;
    end else begin
      data_gnt_q <= rd_req;
      if (wr_req) begin
        for (int b = 0; b < ladybird_config::STRB_W; b++) begin
          if (bus.wstrb[b]) begin
            mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (nrst && rd_req) begin
      rdata_q <= mem[idx]; // sees the old word if a write hit the same edge.
    end
  end

  assign bus.gnt      = 1'b1;
  assign bus.rdata    = rdata_q;
  assign bus.data_gnt = data_gnt_q;

endmodule

`default_nettype wire

// ==== ladybird_inst_ram.sv ====
`default_nettype none

module ladybird_inst_ram #(
  parameter int unsigned ADDR_W = 4
) (
  input  logic           clk,
  input  logic           anrst,
  input  logic           nrst,
  ladybird_bus.secondary bus
);

  localparam int unsigned DEPTH = 2 ** ADDR_W;

  logic [ladybird_config::XLEN-1:0] mem [DEPTH];
  logic [ladybird_config::XLEN-1:0] rdata_q;
  logic [ADDR_W-1:0]                idx;
  logic                             wr_req;
  logic                             rd_req;
  logic                             data_gnt_q;

  assign idx    = bus.addr[ADDR_W+1:2]; // upper address bits wrap.
  assign wr_req = bus.req && (|bus.wstrb);
  assign rd_req = bus.req && !(|bus.wstrb);

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      // the image comes from the shared program.
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= ladybird_config::boot_word(i);
      end
      data_gnt_q <= 1'b0;
    end else if (!nrst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= ladybird_config::boot_word(i); // the level reset reloads the same program.
      end
      data_gnt_q <= 1'b0;
    end else begin
      data_gnt_q <= rd_req;
      if (wr_req) begin
        for (int b = 0; b < ladybird_config::STRB_W; b++) begin
          if (bus.wstrb[b]) begin
            mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // read word is only looked at while data_gnt is high.
  always_ff @(posedge clk) begin
    if (nrst && rd_req) begin
      rdata_q <= mem[idx];
    end
  end

  assign bus.gnt      = 1'b1;
  assign bus.rdata    = rdata_q;
  assign bus.data_gnt = data_gnt_q;

endmodule

`default_nettype wire

// ==== ladybird_bus.sv ====
`default_nettype none

interface ladybird_bus;

  logic                                 req;
  logic [ladybird_config::XLEN-1:0]     addr;
  logic [ladybird_config::STRB_W-1:0]   wstrb;  // zero means read.
  logic [ladybird_config::XLEN-1:0]     wdata;
  logic                                 gnt;
  logic [ladybird_config::XLEN-1:0]     rdata;
  logic                                 data_gnt; // one cycle after a read request.

  modport primary (
    output req, addr, wstrb, wdata,
    input  gnt, rdata, data_gnt
  );

  modport secondary (
    input  req, addr, wstrb, wdata,
    output gnt, rdata, data_gnt
  );

endinterface

`default_nettype wire

// ==== ladybird_config.sv ====
`default_nettype none

package ladybird_config;

  localparam int unsigned XLEN = 32;
  localparam int unsigned STRB_W = XLEN / 8;
  localparam int unsigned BOOT_LEN = 14; // words of real code at the start of the image.

  // major opcodes used by the boot program.
  typedef enum logic [6:0] {
    OP_LUI   = 7'b0110111,
    OP_IMM   = 7'b0010011,
    OP_LOAD  = 7'b0000011,
    OP_STORE = 7'b0100011,
    OP_JAL   = 7'b1101111
  } opcode_e;

  // address bit 31 picks the region.
  typedef enum logic {
    REGION_INST = 1'b0,
    REGION_DATA = 1'b1
  } region_e;

  function automatic logic [XLEN-1:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] funct3, input logic [4:0] rd,
                                             input opcode_e op);
    return {imm, rs1, funct3, rd, op};
  endfunction

  function automatic logic [XLEN-1:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] funct3);
    return {imm[11:5], rs2, rs1, funct3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [XLEN-1:0] LUI(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OP_LUI};
  endfunction

  function automatic logic [XLEN-1:0] ADDI(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return i_type(imm, rs1, 3'b000, rd, OP_IMM);
  endfunction

  function automatic logic [XLEN-1:0] SRAI(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] shamt);
    return i_type({7'b0100000, shamt}, rs1, 3'b101, rd, OP_IMM); // funct7 marks arithmetic.
  endfunction

  function automatic logic [XLEN-1:0] LB(input logic [4:0] rd, input logic [11:0] imm,
                                         input logic [4:0] rs1);
    return i_type(imm, rs1, 3'b000, rd, OP_LOAD);
  endfunction

  function automatic logic [XLEN-1:0] LW(input logic [4:0] rd, input logic [11:0] imm,
                                         input logic [4:0] rs1);
    return i_type(imm, rs1, 3'b010, rd, OP_LOAD);
  endfunction

  function automatic logic [XLEN-1:0] SB(input logic [4:0] rs2, input logic [11:0] imm,
                                         input logic [4:0] rs1);
    return s_type(imm, rs2, rs1, 3'b000);
  endfunction

  function automatic logic [XLEN-1:0] SW(input logic [4:0] rs2, input logic [11:0] imm,
                                         input logic [4:0] rs1);
    return s_type(imm, rs2, rs1, 3'b010);
  endfunction

  // jal with x0 as link register, offset in bytes.
  function automatic logic [XLEN-1:0] J(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, OP_JAL};
  endfunction

  function automatic logic [XLEN-1:0] NOP();
    return ADDI(5'd0, 5'd0, 12'h000);
  endfunction

  function automatic logic [XLEN-1:0] boot_word(input int unsigned idx);
    if (idx >= BOOT_LEN) begin
      return NOP();
    end
    case (idx)
      0:       return LUI(5'd1, 20'hfffff);
      1:       return SRAI(5'd1, 5'd1, 5'd12);
      2:       return LB(5'd2, 12'h000, 5'd1);
      3:       return LUI(5'd3, 20'h90000);
      4:       return LW(5'd4, 12'h000, 5'd3);
      5:       return ADDI(5'd5, 5'd4, 12'h001);
      6:       return LUI(5'd6, 20'h80000);
      7:       return SW(5'd5, 12'h000, 5'd6);
      8:       return LW(5'd7, 12'h000, 5'd6);
      9:       return LUI(5'd8, 20'he0000);
      10:      return ADDI(5'd8, 5'd8, 12'h008);
      11:      return SB(5'd2, 12'h000, 5'd8);
      12:      return SB(5'd7, 12'h000, 5'd1);
      13:      return J(-21'd44); // back to word 2.
      default: return NOP();
    endcase
  endfunction

endpackage

`default_nettype wire
